/* rtl/bp_pkg.sv */
// gshare branch predictor shared definitions
// constants, counter and state encodings, commit, update and
// wishbone bundles used across the predictor blocks
package bp_pkg;

	// ==============================
	// sizes
	// ==============================
	localparam int PC_W        = 32;
	localparam int QSLOTS      = 2;
	localparam int COMMIT_W    = 4;
	localparam int QUEUE_DEPTH = 32;
	localparam int QPTR_W      = 5;
	localparam int HIST_W      = 5;
	localparam int BHT_IDX_W   = 10;
	localparam int BHT_ENTRIES = 1024;
	localparam int WB_ADDR_W   = 2;
	localparam int WB_DATA_W   = 32;

	// ==============================
	// encodings
	// ==============================
	// counter values 0 and 1 predict taken, 2 and 3 predict not taken
	typedef enum logic [1:0] {
		ctr_weak_taken   = 2'd0,
		ctr_strong_taken = 2'd1,
		ctr_strong_not   = 2'd2,
		ctr_weak_not     = 2'd3
	} bp_ctr_e;

	// table init sweep, then normal operation
	typedef enum logic {
		st_sweep,
		st_run
	} bp_init_e;

	// register word addresses
	typedef enum logic [WB_ADDR_W-1:0] {
		reg_ctrl   = 2'd0,
		reg_status = 2'd1,
		reg_count  = 2'd2
	} bp_reg_e;

	// ==============================
	// bundles
	// ==============================
	// one resolved branch from a commit slot
	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] pc;
		logic            taken;
	} bp_resolve_t;

	// all commit slots of one cycle, slot 0 is oldest
	typedef bp_resolve_t [COMMIT_W-1:0] bp_commit_t;

	// one dequeued update headed for the table
	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] pc;
		logic            taken;
	} bp_update_t;

	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic                 ack;
		logic [WB_DATA_W-1:0] dat_r;
	} wb_rsp_t;

endpackage

/* rtl/bp_commit_queue.sv */
// branch resolution queue
// packs up to four resolved branches per cycle into a circular
// buffer and releases one update per cycle to the counter table
`timescale 1ns/10ps

module bp_commit_queue (
	input  logic               clk,
	input  logic               rst,
	input  bp_pkg::bp_commit_t commit,
	output logic               commit_ready,
	input  logic               table_ready,
	output bp_pkg::bp_update_t update,
	output logic               empty
);

	// ==============================
	// storage and pointers
	// ==============================
	// payload memory, no reset needed
	logic [bp_pkg::PC_W-1:0] pc_mem [bp_pkg::QUEUE_DEPTH];
	logic                    taken_mem [bp_pkg::QUEUE_DEPTH];

	logic [bp_pkg::QPTR_W-1:0] head;
	logic [bp_pkg::QPTR_W-1:0] tail;
	// occupancy, one bit wider so a full queue reads 32
	logic [bp_pkg::QPTR_W:0]   count;
	logic [bp_pkg::QPTR_W:0]   free_cnt;

	// per-slot offset from tail and total number of valid slots
	logic [bp_pkg::QPTR_W-1:0] slot_off [bp_pkg::COMMIT_W];
	logic [bp_pkg::QPTR_W:0]   push_cnt;
	logic                      pop;

	// registered update toward the table
	logic                    upd_valid;
	logic [bp_pkg::PC_W-1:0] upd_pc;
	logic                    upd_taken;

	// ==============================
	// commit side
	// ==============================
	// prefix count of valid bits gives each slot its place after tail
	// invalid slots leave no hole
	always_comb begin
		push_cnt = '0;
		for (int i = 0; i < bp_pkg::COMMIT_W; i++) begin
			slot_off[i] = push_cnt[bp_pkg::QPTR_W-1:0];
			push_cnt    = push_cnt + (bp_pkg::QPTR_W + 1)'(commit[i].valid);
		end
	end

	assign free_cnt     = (bp_pkg::QPTR_W + 1)'(bp_pkg::QUEUE_DEPTH) - count;
	// room for a full commit group, so nothing is ever dropped
	assign commit_ready = free_cnt >= (bp_pkg::QPTR_W + 1)'(bp_pkg::COMMIT_W);

	// all valid slots land in one edge, pointer sum wraps at depth
	always_ff @(posedge clk) begin
		for (int i = 0; i < bp_pkg::COMMIT_W; i++) begin
			if (commit_ready && commit[i].valid) begin
				pc_mem[tail + slot_off[i]]    <= commit[i].pc;
				taken_mem[tail + slot_off[i]] <= commit[i].taken;
			end
		end
	end

	// ==============================
	// drain side
	// ==============================
	// table stalls the drain during its init sweep
	assign pop = table_ready && (count != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			upd_valid <= 1'b0;
		end else begin
			if (commit_ready) begin
				tail <= tail + push_cnt[bp_pkg::QPTR_W-1:0];
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			count     <= count + (commit_ready ? push_cnt : '0)
				- (bp_pkg::QPTR_W + 1)'(pop);
			upd_valid <= pop;
		end
	end

	// head entry was written at least one edge earlier
	always_ff @(posedge clk) begin
		if (pop) begin
			upd_pc    <= pc_mem[head];
			upd_taken <= taken_mem[head];
		end
	end

	assign update = '{valid: upd_valid, pc: upd_pc, taken: upd_taken};

	// empty only once the last update has also left the output register
	assign empty = (count == '0) && !upd_valid;

endmodule

/* rtl/bp_gshare_table.sv */
// gshare counter table
// holds the 2-bit counters and global history, sweeps the table to
// weak not-taken after reset, predicts every fetch slot in the same
// cycle and applies one resolved branch per cycle
`timescale 1ns/10ps

module bp_gshare_table (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    enable,
	input  logic [bp_pkg::QSLOTS-1:0][bp_pkg::PC_W-1:0] fetch_pc,
	output logic [bp_pkg::QSLOTS-1:0]               predict_taken,
	input  bp_pkg::bp_update_t                      update,
	output logic                                    ready,
	output logic                                    applied
);

	// ==============================
	// state
	// ==============================
	// counter array, cleared by the sweep and not by reset
	bp_pkg::bp_ctr_e bht [bp_pkg::BHT_ENTRIES];

	logic [bp_pkg::HIST_W-1:0]    hist;
	bp_pkg::bp_init_e             init_state;
	logic [bp_pkg::BHT_IDX_W-1:0] sweep_idx;

	// prediction read side
	logic [bp_pkg::BHT_IDX_W-1:0] rd_idx [bp_pkg::QSLOTS];
	bp_pkg::bp_ctr_e              rd_ctr [bp_pkg::QSLOTS];

	// update side
	logic [bp_pkg::BHT_IDX_W-1:0] upd_idx;
	bp_pkg::bp_ctr_e              upd_ctr;
	bp_pkg::bp_ctr_e              upd_next;

	// single write port shared by sweep and update
	logic                         wr_en;
	logic [bp_pkg::BHT_IDX_W-1:0] wr_idx;
	bp_pkg::bp_ctr_e              wr_ctr;

	// ==============================
	// helpers
	// ==============================
	// low pc bits select the row, history folds into the upper pc bits
	function automatic logic [bp_pkg::BHT_IDX_W-1:0] bht_index(
		input logic [bp_pkg::PC_W-1:0]   pc,
		input logic [bp_pkg::HIST_W-1:0] h
	);
		return {pc[6:2], h ^ pc[11:7]};
	endfunction

	// taken walks 3 -> 0 -> 1 and stops at 1
	// not taken walks 1 -> 0 -> 3 -> 2 and stops at 2
	function automatic bp_pkg::bp_ctr_e ctr_step(
		input bp_pkg::bp_ctr_e ctr,
		input logic            taken
	);
		bp_pkg::bp_ctr_e nxt;
		nxt = ctr;
		if (taken) begin
			if (ctr != bp_pkg::ctr_strong_taken) begin
				nxt = bp_pkg::bp_ctr_e'(ctr + 2'd1);
			end
		end else begin
			if (ctr != bp_pkg::ctr_strong_not) begin
				nxt = bp_pkg::bp_ctr_e'(ctr - 2'd1);
			end
		end
		return nxt;
	endfunction

	assign ready = (init_state == bp_pkg::st_run);

	// ==============================
	// prediction, zero latency
	// ==============================
	always_comb begin
		for (int i = 0; i < bp_pkg::QSLOTS; i++) begin
			rd_idx[i] = bht_index(fetch_pc[i], hist);
			rd_ctr[i] = bht[rd_idx[i]];
			// 0 and 1 are the taken side of the encoding
			predict_taken[i] = enable && ready &&
				((rd_ctr[i] == bp_pkg::ctr_weak_taken) ||
				 (rd_ctr[i] == bp_pkg::ctr_strong_taken));
		end
	end

	// ==============================
	// update path
	// ==============================
	assign upd_idx  = bht_index(update.pc, hist);
	assign upd_ctr  = bht[upd_idx];
	assign upd_next = ctr_step(upd_ctr, update.taken);

	// updates popped while disabled fall on the floor
	assign applied = update.valid && enable && ready;

	assign wr_en  = !ready || applied;
	assign wr_idx = ready ? upd_idx : sweep_idx;
	assign wr_ctr = ready ? upd_next : bp_pkg::ctr_weak_not;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			bht[wr_idx] <= wr_ctr;
		end
	end

	// sweep sequencer and history
	always_ff @(posedge clk) begin
		if (rst) begin
			init_state <= bp_pkg::st_sweep;
			sweep_idx  <= '0;
			hist       <= '0;
		end else begin
			if (init_state == bp_pkg::st_sweep) begin
				sweep_idx <= sweep_idx + 1'b1;
				// last index is all ones, table fully written
				if (&sweep_idx) begin
					init_state <= bp_pkg::st_run;
				end
			end
			if (applied) begin
				hist <= {hist[bp_pkg::HIST_W-2:0], update.taken};
			end
		end
	end

endmodule

/* rtl/bp_wb_regs.sv */
// predictor register block
// wishbone classic slave with the enable control, queue and table
// status and a count of updates applied to the table
`timescale 1ns/10ps

module bp_wb_regs (
	input  logic            clk,
	input  logic            rst,
	input  bp_pkg::wb_req_t wb_req,
	output bp_pkg::wb_rsp_t wb_rsp,
	output logic            enable,
	input  logic            queue_empty,
	input  logic            table_ready,
	input  logic            applied
);

	// ==============================
	// bus decode
	// ==============================
	logic                         ack_q;
	logic [bp_pkg::WB_DATA_W-1:0] dat_r_q;
	logic                         req_hit;
	logic                         wr_hit;
	bp_pkg::bp_reg_e              reg_sel;
	logic [bp_pkg::WB_DATA_W-1:0] rd_data;

	logic                         enable_q;
	logic [bp_pkg::WB_DATA_W-1:0] applied_cnt;

	// new request only when ack is not already out,
	// keeps ack to one cycle per transfer
	assign req_hit = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_hit  = req_hit && wb_req.we;
	assign reg_sel = bp_pkg::bp_reg_e'(wb_req.adr);

	// read mux, unmapped word reads zero
	always_comb begin
		rd_data = '0;
		case (reg_sel)
			bp_pkg::reg_ctrl: begin
				rd_data[0] = enable_q;
			end
			bp_pkg::reg_status: begin
				rd_data[0] = queue_empty;
				rd_data[1] = table_ready;
			end
			bp_pkg::reg_count: begin
				rd_data = applied_cnt;
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	// ==============================
	// registers
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q       <= 1'b0;
			enable_q    <= 1'b0;
			applied_cnt <= '0;
		end else begin
			ack_q <= req_hit;
			if (wr_hit && (reg_sel == bp_pkg::reg_ctrl)) begin
				enable_q <= wb_req.dat_w[0];
			end
			// any write clears, clear wins over a same-cycle update
			if (wr_hit && (reg_sel == bp_pkg::reg_count)) begin
				applied_cnt <= '0;
			end else if (applied) begin
				applied_cnt <= applied_cnt + 1'b1;
			end
		end
	end

	// read data sampled with the request, valid alongside ack
	always_ff @(posedge clk) begin
		if (req_hit) begin
			dat_r_q <= rd_data;
		end
	end

	assign wb_rsp = '{ack: ack_q, dat_r: dat_r_q};
	assign enable = enable_q;

endmodule

/* rtl/bp_top.sv */
// gshare branch direction predictor
// commit queue feeds the counter table one update per cycle,
// register block controls enable and reports status and count
`timescale 1ns/10ps

module bp_top (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [bp_pkg::QSLOTS-1:0][bp_pkg::PC_W-1:0] fetch_pc,
	output logic [bp_pkg::QSLOTS-1:0]               predict_taken,
	input  bp_pkg::bp_commit_t                      commit,
	output logic                                    commit_ready,
	input  bp_pkg::wb_req_t                         wb_req,
	output bp_pkg::wb_rsp_t                         wb_rsp
);

	// ==============================
	// internal nets
	// ==============================
	// queue to table
	bp_pkg::bp_update_t update;
	// table readiness gates the drain and shows in status
	logic               table_ready;
	logic               queue_empty;
	// one pulse per counter written
	logic               applied;
	logic               enable;

	// resolved branches in, one update per cycle out
	bp_commit_queue u_queue (
		.clk          (clk),
		.rst          (rst),
		.commit       (commit),
		.commit_ready (commit_ready),
		.table_ready  (table_ready),
		.update       (update),
		.empty        (queue_empty)
	);

	// counters, history and fetch predictions
	bp_gshare_table u_table (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.fetch_pc      (fetch_pc),
		.predict_taken (predict_taken),
		.update        (update),
		.ready         (table_ready),
		.applied       (applied)
	);

	// control and status over wishbone
	bp_wb_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.enable      (enable),
		.queue_empty (queue_empty),
		.table_ready (table_ready),
		.applied     (applied)
	);

endmodule

/* verif/bp_tb.sv */
// gshare predictor testbench
// drives commits, fetch pcs and wishbone accesses into bp_top,
// keeps a reference model of the counter table and history,
// and compares predictions, status and the applied-update count
`timescale 1ns/10ps

module bp_tb;

	// ==============================
	// dut signals
	// ==============================
	logic                                        clk;
	logic                                        rst;
	logic [bp_pkg::QSLOTS-1:0][bp_pkg::PC_W-1:0] fetch_pc;
	logic [bp_pkg::QSLOTS-1:0]                   predict_taken;
	bp_pkg::bp_commit_t                          commit;
	logic                                        commit_ready;
	bp_pkg::wb_req_t                             wb_req;
	bp_pkg::wb_rsp_t                             wb_rsp;

	// stimulus and model state
	logic [31:0]               lfsr;
	logic [1:0]                ref_ctr [bp_pkg::BHT_ENTRIES];
	logic [bp_pkg::HIST_W-1:0] ref_hist;
	logic                      model_enable;
	int                        expected_count;
	int                        stall_cycles;
	logic                      pred_check;
	string                     test_name;

	bp_top dut (
		.clk           (clk),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.predict_taken (predict_taken),
		.commit        (commit),
		.commit_ready  (commit_ready),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// ==============================
	// random source and reference model
	// ==============================
	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit handed out
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// pc bits 6..2 pick the row and history folds onto pc bits 11..7
	function automatic logic [bp_pkg::BHT_IDX_W-1:0] table_index(input logic [31:0] pc);
		return {pc[6:2], ref_hist ^ pc[11:7]};
	endfunction

	// taken walks 2 -> 3 -> 0 -> 1 and holds at 1
	// not taken walks 1 -> 0 -> 3 -> 2 and holds at 2
	function automatic logic [1:0] next_ctr(input logic [1:0] ctr, input logic taken);
		case ({taken, ctr})
			3'b1_00: return 2'd1;
			3'b1_01: return 2'd1;
			3'b1_10: return 2'd3;
			3'b1_11: return 2'd0;
			3'b0_00: return 2'd3;
			3'b0_01: return 2'd0;
			3'b0_10: return 2'd2;
			default: return 2'd2;
		endcase
	endfunction

	// expected prediction where 0 and 1 mean taken
	function automatic logic predict(input logic [31:0] pc);
		return model_enable && (ref_ctr[table_index(pc)] <= 2'd1);
	endfunction

	// branches reach the table in commit order and are dropped while disabled
	task automatic apply_branch(input logic [31:0] pc, input logic taken);
		logic [bp_pkg::BHT_IDX_W-1:0] idx;
		if (model_enable) begin
			idx          = table_index(pc);
			ref_ctr[idx] = next_ctr(ref_ctr[idx], taken);
			ref_hist     = {ref_hist[bp_pkg::HIST_W-2:0], taken};
			expected_count++;
		end
	endtask

	// ==============================
	// checking
	// ==============================
	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// both fetch slots against the model on the edge between two drives
	always @(posedge clk) begin
		if (pred_check) begin
			for (int i = 0; i < bp_pkg::QSLOTS; i++) begin
				check("predict_taken", 32'(predict(fetch_pc[i])), 32'(predict_taken[i]));
			end
		end
	end

	// sweep plus per-test cycle budgets
	initial begin
		int wd_cycles;
		wd_cycles = bp_pkg::BHT_ENTRIES + 600 + 400 + 800 + 500 + 500 + 300;
		#(wd_cycles * 8 + 2000);
		$display("ERROR %s: watchdog expired, the run did not finish in time", test_name);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	// ==============================
	// bus and commit drivers
	// ==============================
	// all drivers start and end on a falling edge
	task automatic wb_write(input bp_pkg::bp_reg_e adr, input logic [31:0] data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
		do @(negedge clk); while (!wb_rsp.ack);
		wb_req = '0;
	endtask

	task automatic wb_read(input bp_pkg::bp_reg_e adr, output logic [31:0] data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: '0};
		do @(negedge clk); while (!wb_rsp.ack);
		data   = wb_rsp.dat_r;
		wb_req = '0;
	endtask

	// bounded poll of one status bit
	task automatic wait_status(input int bit_sel, input string what);
		logic [31:0] st;
		int          tries;
		st    = '0;
		tries = 0;
		while (!st[bit_sel] && tries < 4 * bp_pkg::BHT_ENTRIES) begin
			wb_read(bp_pkg::reg_status, st);
			tries++;
		end
		if (!st[bit_sel]) begin
			$display("ERROR %s: %s never came up in the status register", test_name, what);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_count();
		logic [31:0] cnt;
		wb_read(bp_pkg::reg_count, cnt);
		check("applied count", expected_count, cnt);
	endtask

	// hold with no valid slots while the queue is short of room
	task automatic send_group(input bp_pkg::bp_commit_t grp);
		while (!commit_ready) begin
			commit = '0;
			stall_cycles++;
			@(negedge clk);
		end
		commit = grp;
		for (int i = 0; i < bp_pkg::COMMIT_W; i++) begin
			if (grp[i].valid) begin
				apply_branch(grp[i].pc, grp[i].taken);
			end
		end
		@(negedge clk);
		commit = '0;
	endtask

	task automatic random_group(input logic all_valid, output bp_pkg::bp_commit_t grp);
		logic [31:0] v;
		logic [31:0] pc;
		logic [31:0] t;
		for (int i = 0; i < bp_pkg::COMMIT_W; i++) begin
			rand_bits(1, v);
			rand_bits(32, pc);
			rand_bits(1, t);
			grp[i] = '{valid: all_valid | v[0], pc: pc, taken: t[0]};
		end
	endtask

	task automatic random_predictions(input int n);
		logic [31:0] a;
		logic [31:0] b;
		pred_check = 1'b1;
		repeat (n) begin
			rand_bits(32, a);
			rand_bits(32, b);
			fetch_pc[0] = a;
			fetch_pc[1] = b;
			@(negedge clk);
		end
		pred_check = 1'b0;
	endtask

	// ==============================
	// tests
	// ==============================
	initial begin
		bp_pkg::bp_commit_t grp;
		logic [31:0]        rd;
		logic [31:0]        train_pc;
		clk            = 1'b0;
		rst            = 1'b1;
		fetch_pc       = '0;
		commit         = '0;
		wb_req         = '0;
		lfsr           = 32'hce0fa2ab;
		ref_hist       = '0;
		model_enable   = 1'b0;
		expected_count = 0;
		stall_cycles   = 0;
		pred_check     = 1'b0;
		test_name      = "reset";
		// whole table starts weak not-taken
		for (int i = 0; i < bp_pkg::BHT_ENTRIES; i++) begin
			ref_ctr[i] = 2'd3;
		end
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// reset values and then the end of the sweep
		check("commit_ready", 1, 32'(commit_ready));
		wb_read(bp_pkg::reg_ctrl, rd);
		check("ctrl", 0, rd);
		wb_read(bp_pkg::reg_status, rd);
		check("status during sweep", 32'h1, rd);
		wait_status(1, "table ready");
		check_count();
		wb_write(bp_pkg::reg_ctrl, 32'h1);
		model_enable = 1'b1;
		wb_read(bp_pkg::reg_ctrl, rd);
		check("ctrl after enable", 1, rd);
		random_predictions(16);

		// same branch taken again and again
		test_name = "training";
		rand_bits(32, train_pc);
		repeat (12) begin
			grp    = '0;
			grp[0] = '{valid: 1'b1, pc: train_pc, taken: 1'b1};
			send_group(grp);
		end
		wait_status(0, "queue empty");
		check_count();
		// slot 1 differs only outside the index bits
		pred_check  = 1'b1;
		fetch_pc[0] = train_pc;
		fetch_pc[1] = train_pc ^ 32'hffff_f003;
		@(negedge clk);
		pred_check = 1'b0;
		check("trained pc taken", 1, 32'(predict_taken[0]));

		test_name = "random mix";
		repeat (40) begin
			random_group(1'b0, grp);
			send_group(grp);
		end
		wait_status(0, "queue empty");
		check_count();
		random_predictions(24);

		// four valid slots every cycle outrun the drain
		test_name    = "back-pressure";
		stall_cycles = 0;
		repeat (40) begin
			random_group(1'b1, grp);
			send_group(grp);
		end
		check("commit_ready dropped", 1, 32'(stall_cycles != 0));
		wait_status(0, "queue empty");
		check_count();
		random_predictions(24);

		// popped updates are dropped and the model stands still
		test_name = "disable";
		wb_write(bp_pkg::reg_ctrl, 32'h0);
		model_enable = 1'b0;
		repeat (10) begin
			random_group(1'b0, grp);
			send_group(grp);
		end
		wait_status(0, "queue empty");
		check_count();
		random_predictions(12);
		wb_write(bp_pkg::reg_ctrl, 32'h1);
		model_enable = 1'b1;
		random_predictions(24);

		test_name = "count clear";
		wb_write(bp_pkg::reg_count, 32'h1234);
		expected_count = 0;
		check_count();
		repeat (6) begin
			random_group(1'b0, grp);
			grp[1] = '0;
			grp[2] = '0;
			grp[3] = '0;
			grp[0].valid = 1'b1;
			send_group(grp);
		end
		wait_status(0, "queue empty");
		check_count();
		random_predictions(8);

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* filelist.f */
rtl/bp_pkg.sv
rtl/bp_commit_queue.sv
rtl/bp_gshare_table.sv
rtl/bp_wb_regs.sv
rtl/bp_top.sv
verif/bp_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the gshare predictor testbench with verilator and run it
# the run passes only when the simulation prints the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module bp_tb -o bp_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/bp_sim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
